// File: periph_soc.f
verilog/periph_pkg.sv
verilog/apb_decoder.sv
verilog/apb_gpio.sv
verilog/apb_timer.sv
verilog/apb_event_unit.sv
verilog/rst_ctrl_unit.sv
verilog/periph_soc.sv
testbench/tb_periph_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_periph_soc
FILELIST  ?= periph_soc.f
BUILD_DIR ?= obj_dir
EXE       ?= V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(EXE)
	-$(BUILD_DIR)/$(EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_periph_soc.sv
`default_nettype none

module tb_periph_soc;

  localparam logic [31:0] BOOT_ADDR      = 32'h1C00_0080;
  // 5 tests of at most ~60 cycles each, with wide headroom
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          PREADY_LIMIT   = 16;

  localparam logic [31:0] GPIO_OUT_ADDR   = 32'h1A10_0000;
  localparam logic [31:0] GPIO_IN_ADDR    = 32'h1A10_0004;
  localparam logic [31:0] GPIO_IRQEN_ADDR = 32'h1A10_0008;
  localparam logic [31:0] TIMER_CTRL_ADDR = 32'h1A10_1000;
  localparam logic [31:0] TIMER_CNT_ADDR  = 32'h1A10_1004;
  localparam logic [31:0] TIMER_CMP_ADDR  = 32'h1A10_1008;
  localparam logic [31:0] EVT_EN_ADDR     = 32'h1A10_2000;
  localparam logic [31:0] EVT_PEND_ADDR   = 32'h1A10_2004;
  localparam logic [31:0] EVT_CLR_ADDR    = 32'h1A10_2008;
  localparam logic [31:0] RST_BOOT_ADDR   = 32'h1A10_3000;
  localparam logic [31:0] UNMAPPED_ADDR   = 32'h1A10_8000;

  logic                 core_clk;
  logic                 reset_n;
  periph_pkg::apb_req_t apb_req;
  periph_pkg::apb_rsp_t apb_rsp;
  logic [3:0]           gpio_in;
  logic [11:0]          gpio_out;
  logic                 irq_req;
  logic [4:0]           irq_id;
  logic [31:0]          rst_addr;

  int          seed = 34886;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  int          errs_before;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        slverr;

  periph_soc #(
    .DEFAULT_BOOT_ADDR (BOOT_ADDR)
  ) dut_i (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .irq_req_o  (irq_req),
    .irq_id_o   (irq_id),
    .rst_addr_o (rst_addr)
  );

  always #4 core_clk = ~core_clk;

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // Setup and access cycle, response sampled mid low phase of the access cycle
  task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
    int waits = 0;
    @(negedge core_clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge core_clk);
    apb_req.penable = 1'b1;
    #2;
    while (!apb_rsp.pready && waits < PREADY_LIMIT) begin
      @(negedge core_clk);
      #2;
      waits++;
    end
    check_count++;
    assert (apb_rsp.pready) else begin
      $display("APB transfer to %h got no pready within %0d cycles", addr, PREADY_LIMIT);
      error_count++;
    end
    rd  = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(negedge core_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        unused_err;
    apb_transfer(1'b1, addr, data, unused_rd, unused_err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic wait_for_irq_id(input logic [4:0] id, input int max_cycles);
    int n = 0;
    while (!(irq_req && irq_id == id) && n < max_cycles) begin
      @(negedge core_clk);
      n++;
    end
    expect_equal("irq_req_o", 32'(irq_req), 32'h1);
    expect_equal("irq_id_o", 32'(irq_id), 32'(id));
  endtask

  task automatic report_test(input int num, input string name, input int errs_at_start);
    if (error_count == errs_at_start) $display("Test %0d %s: ok", num, name);
    else $display("Test %0d %s: FAILED with %0d errors", num, name, error_count - errs_at_start);
  endtask

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge core_clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    core_clk = 1'b0;
    reset_n  = 1'b0;
    apb_req  = '0;
    gpio_in  = 4'h0;
    repeat (2) @(negedge core_clk);
    reset_n = 1'b1;

    errs_before = error_count;
    expect_equal("rst_addr_o after reset", rst_addr, BOOT_ADDR);
    expect_equal("gpio_out_o after reset", 32'(gpio_out), 32'h0);
    expect_equal("irq_req_o after reset", 32'(irq_req), 32'h0);
    wdata = $random(seed);
    apb_write(RST_BOOT_ADDR, wdata);
    expect_equal("rst_addr_o after write", rst_addr, wdata);
    apb_read(RST_BOOT_ADDR, rdata, slverr);
    expect_equal("boot address readback", rdata, wdata);
    report_test(1, "reset and boot address", errs_before);

    errs_before = error_count;
    wdata = $random(seed);
    apb_write(GPIO_OUT_ADDR, wdata);
    expect_equal("gpio_out_o", 32'(gpio_out), wdata & 32'h0000_0FFF);
    apb_read(GPIO_OUT_ADDR, rdata, slverr);
    expect_equal("gpio out readback", rdata, wdata & 32'h0000_0FFF);
    gpio_in = 4'($random(seed));
    repeat (3) @(negedge core_clk); // Two-flop synchronizer
    apb_read(GPIO_IN_ADDR, rdata, slverr);
    expect_equal("gpio in readback", rdata, 32'(gpio_in));
    report_test(2, "GPIO", errs_before);

    errs_before = error_count;
    apb_read(UNMAPPED_ADDR, rdata, slverr);
    expect_equal("unmapped pslverr", 32'(slverr), 32'h1);
    expect_equal("unmapped prdata", rdata, 32'h0);
    apb_read(RST_BOOT_ADDR, rdata, slverr);
    expect_equal("mapped pslverr", 32'(slverr), 32'h0);
    report_test(3, "unmapped address", errs_before);

    errs_before = error_count;
    apb_write(TIMER_CMP_ADDR, 32'd20);
    apb_write(EVT_EN_ADDR, 32'h1 << 25);
    apb_write(TIMER_CTRL_ADDR, 32'h1);
    wait_for_irq_id(5'd25, 40);
    apb_read(EVT_PEND_ADDR, rdata, slverr);
    expect_equal("pending bit 25", {31'b0, rdata[25]}, 32'h1);
    apb_write(TIMER_CTRL_ADDR, 32'h0); // Stop before clearing
    apb_write(EVT_CLR_ADDR, 32'h1 << 25);
    expect_equal("irq_req_o after clear", 32'(irq_req), 32'h0);
    report_test(4, "timer interrupt", errs_before);

    errs_before = error_count;
    gpio_in = 4'b0001;
    apb_write(GPIO_IRQEN_ADDR, 32'h1);
    apb_write(EVT_EN_ADDR, (32'h1 << 24) | (32'h1 << 25));
    wait_for_irq_id(5'd24, 10);
    apb_write(TIMER_CNT_ADDR, 32'h0);
    apb_write(TIMER_CTRL_ADDR, 32'h1);
    wait_for_irq_id(5'd25, 40);
    apb_write(TIMER_CTRL_ADDR, 32'h0);
    apb_write(EVT_CLR_ADDR, 32'h1 << 25);
    expect_equal("irq_id_o after clear", 32'(irq_id), 32'd24);
    report_test(5, "priority", errs_before);

    $display("Summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/periph_soc.sv
`default_nettype none

module periph_soc #(
  parameter logic [31:0] DEFAULT_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                                core_clk,
  input  logic                                reset_n,
  input  periph_pkg::apb_req_t                apb_req_i,
  output periph_pkg::apb_rsp_t                apb_rsp_o,
  input  logic [periph_pkg::GPIO_IN_W-1:0]    gpio_in_i,
  output logic [periph_pkg::GPIO_OUT_W-1:0]   gpio_out_o,
  output logic                                irq_req_o,
  output logic [periph_pkg::IRQ_ID_W-1:0]     irq_id_o,
  output logic [31:0]                         rst_addr_o
);

  logic [periph_pkg::SLAVE_NUM-1:0] slv_sel;
  periph_pkg::apb_rsp_t             slv_rsp [periph_pkg::SLAVE_NUM];
  logic                             gpio_event;
  logic                             timer_irq;
  logic [periph_pkg::IRQ_NUM-1:0]   irq_src;

  // Sources sit at their fixed IRQ positions, all other lines tied low
  assign irq_src = ({{(periph_pkg::IRQ_NUM-1){1'b0}}, gpio_event} << periph_pkg::IRQ_GPIO) |
                   ({{(periph_pkg::IRQ_NUM-1){1'b0}}, timer_irq}  << periph_pkg::IRQ_TIMER);

  apb_decoder decoder_i (
    .core_clk  (core_clk),
    .reset_n   (reset_n),
    .apb_req_i (apb_req_i),
    .slv_sel_o (slv_sel),
    .slv_rsp_i (slv_rsp),
    .apb_rsp_o (apb_rsp_o)
  );

  apb_gpio gpio_i (
    .core_clk     (core_clk),
    .reset_n      (reset_n),
    .apb_req_i    (apb_req_i),
    .sel_i        (slv_sel[periph_pkg::SLV_GPIO]),
    .apb_rsp_o    (slv_rsp[periph_pkg::SLV_GPIO]),
    .gpio_in_i    (gpio_in_i),
    .gpio_out_o   (gpio_out_o),
    .gpio_event_o (gpio_event)
  );

  apb_timer timer_i (
    .core_clk    (core_clk),
    .reset_n     (reset_n),
    .apb_req_i   (apb_req_i),
    .sel_i       (slv_sel[periph_pkg::SLV_TIMER]),
    .apb_rsp_o   (slv_rsp[periph_pkg::SLV_TIMER]),
    .timer_irq_o (timer_irq)
  );

  apb_event_unit event_unit_i (
    .core_clk  (core_clk),
    .reset_n   (reset_n),
    .apb_req_i (apb_req_i),
    .sel_i     (slv_sel[periph_pkg::SLV_EVENT]),
    .apb_rsp_o (slv_rsp[periph_pkg::SLV_EVENT]),
    .irq_src_i (irq_src),
    .irq_req_o (irq_req_o),
    .irq_id_o  (irq_id_o)
  );

  rst_ctrl_unit #(
    .DEFAULT_BOOT_ADDR (DEFAULT_BOOT_ADDR)
  ) rst_ctrl_i (
    .core_clk   (core_clk),
    .reset_n    (reset_n),
    .apb_req_i  (apb_req_i),
    .sel_i      (slv_sel[periph_pkg::SLV_RSTCTRL]),
    .apb_rsp_o  (slv_rsp[periph_pkg::SLV_RSTCTRL]),
    .rst_addr_o (rst_addr_o)
  );

endmodule

`default_nettype wire

// File: verilog/rst_ctrl_unit.sv
`default_nettype none

module rst_ctrl_unit #(
  parameter logic [31:0] DEFAULT_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                 core_clk,
  input  logic                 reset_n,
  input  periph_pkg::apb_req_t apb_req_i,
  input  logic                 sel_i,
  output periph_pkg::apb_rsp_t apb_rsp_o,
  output logic [31:0]          rst_addr_o
);

  logic [11:0] offset;
  logic        wr_en;

  assign offset = apb_req_i.paddr[11:0];
  assign wr_en  = sel_i && apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite &&
                  (offset == periph_pkg::REG_RST_BOOT);

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      rst_addr_o <= DEFAULT_BOOT_ADDR; // Boot vector after reset
    end else if (wr_en) begin
      rst_addr_o <= apb_req_i.pwdata;
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    if (offset == periph_pkg::REG_RST_BOOT) begin
      apb_rsp_o.prdata = rst_addr_o;
    end
  end

endmodule

`default_nettype wire

// File: verilog/apb_event_unit.sv
`default_nettype none

module apb_event_unit (
  input  logic                            core_clk,
  input  logic                            reset_n,
  input  periph_pkg::apb_req_t            apb_req_i,
  input  logic                            sel_i,
  output periph_pkg::apb_rsp_t            apb_rsp_o,
  input  logic [periph_pkg::IRQ_NUM-1:0]  irq_src_i,
  output logic                            irq_req_o,
  output logic [periph_pkg::IRQ_ID_W-1:0] irq_id_o
);

  logic [periph_pkg::IRQ_NUM-1:0] enable_q;
  logic [periph_pkg::IRQ_NUM-1:0] pending_q;
  logic [periph_pkg::IRQ_NUM-1:0] clear_mask;
  logic [periph_pkg::IRQ_NUM-1:0] active;
  logic [11:0]                    offset;
  logic                           wr_en;

  assign offset = apb_req_i.paddr[11:0];
  assign wr_en  = sel_i && apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;

  assign clear_mask = (wr_en && (offset == periph_pkg::REG_EVT_CLEAR)) ?
                      apb_req_i.pwdata[periph_pkg::IRQ_NUM-1:0] : '0;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      enable_q  <= '0;
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~clear_mask) | irq_src_i; // Set beats clear
      if (wr_en && (offset == periph_pkg::REG_EVT_ENABLE)) begin
        enable_q <= apb_req_i.pwdata[periph_pkg::IRQ_NUM-1:0];
      end
    end
  end

  assign active    = pending_q & enable_q;
  assign irq_req_o = |active;

  // Highest index wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < periph_pkg::IRQ_NUM; i++) begin
      if (active[i]) begin
        irq_id_o = i[periph_pkg::IRQ_ID_W-1:0];
      end
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (offset)
      periph_pkg::REG_EVT_ENABLE:  apb_rsp_o.prdata[periph_pkg::IRQ_NUM-1:0] = enable_q;
      periph_pkg::REG_EVT_PENDING: apb_rsp_o.prdata[periph_pkg::IRQ_NUM-1:0] = pending_q;
      default: ;
    endcase
  end

  assert property (@(posedge core_clk) disable iff (!reset_n)
    irq_req_o |-> active[irq_id_o]);

endmodule

`default_nettype wire

// File: verilog/apb_timer.sv
`default_nettype none

module apb_timer (
  input  logic                 core_clk,
  input  logic                 reset_n,
  input  periph_pkg::apb_req_t apb_req_i,
  input  logic                 sel_i,
  output periph_pkg::apb_rsp_t apb_rsp_o,
  output logic                 timer_irq_o
);

  logic                              enable_q;
  logic [periph_pkg::APB_DATA_W-1:0] count_q;
  logic [periph_pkg::APB_DATA_W-1:0] cmp_q;
  logic [11:0]                       offset;
  logic                              wr_en;
  logic                              match;

  assign offset = apb_req_i.paddr[11:0];
  assign wr_en  = sel_i && apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;

  // Zero compare value keeps the channel silent
  assign match       = enable_q && (cmp_q != '0) && (count_q == cmp_q);
  assign timer_irq_o = match;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (offset == periph_pkg::REG_TIMER_CTRL) begin
        enable_q <= apb_req_i.pwdata[0];
      end
      if (offset == periph_pkg::REG_TIMER_CMP) begin
        cmp_q <= apb_req_i.pwdata;
      end
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      count_q <= '0;
    end else if (wr_en && (offset == periph_pkg::REG_TIMER_COUNT)) begin
      count_q <= apb_req_i.pwdata; // Software load wins
    end else if (match) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (offset)
      periph_pkg::REG_TIMER_CTRL:  apb_rsp_o.prdata[0] = enable_q;
      periph_pkg::REG_TIMER_COUNT: apb_rsp_o.prdata    = count_q;
      periph_pkg::REG_TIMER_CMP:   apb_rsp_o.prdata    = cmp_q;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/apb_gpio.sv
`default_nettype none

module apb_gpio (
  input  logic                              core_clk,
  input  logic                              reset_n,
  input  periph_pkg::apb_req_t              apb_req_i,
  input  logic                              sel_i,
  output periph_pkg::apb_rsp_t              apb_rsp_o,
  input  logic [periph_pkg::GPIO_IN_W-1:0]  gpio_in_i,
  output logic [periph_pkg::GPIO_OUT_W-1:0] gpio_out_o,
  output logic                              gpio_event_o
);

  logic [periph_pkg::GPIO_IN_W-1:0] sync_meta_q;
  logic [periph_pkg::GPIO_IN_W-1:0] sync_q;
  logic [periph_pkg::GPIO_IN_W-1:0] irqen_q;
  logic [11:0]                      offset;
  logic                             wr_en;

  assign offset = apb_req_i.paddr[11:0];
  assign wr_en  = sel_i && apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite;

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      sync_meta_q <= '0;
      sync_q      <= '0;
    end else begin
      sync_meta_q <= gpio_in_i; // Pins are asynchronous
      sync_q      <= sync_meta_q;
    end
  end

  always_ff @(posedge core_clk or negedge reset_n) begin
    if (!reset_n) begin
      gpio_out_o <= '0;
      irqen_q    <= '0;
    end else if (wr_en) begin
      if (offset == periph_pkg::REG_GPIO_OUT) begin
        gpio_out_o <= apb_req_i.pwdata[periph_pkg::GPIO_OUT_W-1:0];
      end
      if (offset == periph_pkg::REG_GPIO_IRQEN) begin
        irqen_q <= apb_req_i.pwdata[periph_pkg::GPIO_IN_W-1:0];
      end
    end
  end

  assign gpio_event_o = |(sync_q & irqen_q);

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    case (offset)
      periph_pkg::REG_GPIO_OUT:   apb_rsp_o.prdata[periph_pkg::GPIO_OUT_W-1:0] = gpio_out_o;
      periph_pkg::REG_GPIO_IN:    apb_rsp_o.prdata[periph_pkg::GPIO_IN_W-1:0]  = sync_q;
      periph_pkg::REG_GPIO_IRQEN: apb_rsp_o.prdata[periph_pkg::GPIO_IN_W-1:0]  = irqen_q;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/apb_decoder.sv
`default_nettype none

module apb_decoder (
  input  logic                             core_clk,
  input  logic                             reset_n,
  input  periph_pkg::apb_req_t             apb_req_i,
  output logic [periph_pkg::SLAVE_NUM-1:0] slv_sel_o,
  input  periph_pkg::apb_rsp_t             slv_rsp_i [periph_pkg::SLAVE_NUM],
  output periph_pkg::apb_rsp_t             apb_rsp_o
);

  logic [periph_pkg::APB_ADDR_W-1:0] slv_base [periph_pkg::SLAVE_NUM];
  logic [periph_pkg::APB_ADDR_W-1:0] slv_mask [periph_pkg::SLAVE_NUM];

  for (genvar k = 0; k < periph_pkg::SLAVE_NUM; k++) begin : g_map
    assign slv_base[k] = periph_pkg::SLV_ADDR_START[k];
    // Window size sets the don't-care bits
    assign slv_mask[k] = ~(periph_pkg::SLV_ADDR_END[k] - periph_pkg::SLV_ADDR_START[k]);
    assign slv_sel_o[k] = apb_req_i.psel &&
                          ((apb_req_i.paddr & slv_mask[k]) == (slv_base[k] & slv_mask[k]));
  end

  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    if (apb_req_i.psel && (slv_sel_o == '0)) begin
      apb_rsp_o.pslverr = 1'b1; // Unmapped address
    end
    for (int k = 0; k < periph_pkg::SLAVE_NUM; k++) begin
      if (slv_sel_o[k]) begin
        apb_rsp_o = slv_rsp_i[k];
      end
    end
  end

  // Windows must not overlap
  assert property (@(posedge core_clk) disable iff (!reset_n)
    $onehot0(slv_sel_o));

  // Access phase only follows a select
  assert property (@(posedge core_clk) disable iff (!reset_n)
    apb_req_i.penable |-> apb_req_i.psel);

endmodule

`default_nettype wire

// File: verilog/periph_pkg.sv
`default_nettype none

package periph_pkg;

  localparam int APB_ADDR_W = 32;
  localparam int APB_DATA_W = 32;
  localparam int SLAVE_NUM  = 4;

  localparam int GPIO_OUT_W = 12;
  localparam int GPIO_IN_W  = 4;
  localparam int IRQ_NUM    = 32;
  localparam int IRQ_ID_W   = 5;

  // Slave order in the address map
  localparam int SLV_GPIO    = 0;
  localparam int SLV_TIMER   = 1;
  localparam int SLV_EVENT   = 2;
  localparam int SLV_RSTCTRL = 3;

  localparam logic [APB_ADDR_W-1:0] SLV_ADDR_START [SLAVE_NUM] = '{
    32'h1A10_0000, 32'h1A10_1000, 32'h1A10_2000, 32'h1A10_3000
  };
  localparam logic [APB_ADDR_W-1:0] SLV_ADDR_END [SLAVE_NUM] = '{
    32'h1A10_0FFF, 32'h1A10_1FFF, 32'h1A10_2FFF, 32'h1A10_3FFF
  };

  localparam logic [11:0] REG_GPIO_OUT    = 12'h000;
  localparam logic [11:0] REG_GPIO_IN     = 12'h004;
  localparam logic [11:0] REG_GPIO_IRQEN  = 12'h008;
  localparam logic [11:0] REG_TIMER_CTRL  = 12'h000; // Bit 0 enables counting
  localparam logic [11:0] REG_TIMER_COUNT = 12'h004;
  localparam logic [11:0] REG_TIMER_CMP   = 12'h008;
  localparam logic [11:0] REG_EVT_ENABLE  = 12'h000;
  localparam logic [11:0] REG_EVT_PENDING = 12'h004;
  localparam logic [11:0] REG_EVT_CLEAR   = 12'h008;
  localparam logic [11:0] REG_RST_BOOT    = 12'h000;

  // Interrupt source positions
  localparam int IRQ_GPIO  = 24;
  localparam int IRQ_TIMER = 25;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
